/* flist.f */
+incdir+include
src/fetch_bus_pkg.sv
src/instr_pkg.sv
src/fetch_request_gen.sv
src/prefetch_queue.sv
src/instr_assembler.sv
src/regnum_predecode.sv
src/riscv_frontend.sv
verification/frontend_assertions.sv
verification/tb_frontend.sv

/* run_sim.sh */
#!/bin/sh
# builds the front end testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_frontend -f flist.f

out=$(./obj_dir/Vtb_frontend)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi

/* verification/tb_frontend.sv */
// random-stall testbench; memory latency is 1 to 3 cycles, jump targets stay in 0x1000-0x1ffe
`include "frontend_config.svh"

module tb_frontend
	import fetch_bus_pkg::*;
	import instr_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int run_cycles = 4000;
	localparam int rst_cycles = 10;
	localparam int starve_limit = 64;
	localparam int jump_limit = 64;
	// words in this range come back with a bus error
	localparam fetch_addr_t err_lo = 32'h0000_1040;
	localparam fetch_addr_t err_hi = 32'h0000_1060;

	logic        clk = 1'b0;
	logic        rst_n;
	fetch_addr_t mem_addr;
	logic        mem_addr_vld;
	logic        mem_addr_rdy;
	bus_word_t   mem_data;
	logic        mem_data_err;
	logic        mem_data_vld;
	fetch_addr_t jump_target;
	logic        jump_target_vld;
	logic        jump_target_rdy;
	cir_t        cir;
	cir_level_t  cir_vld;
	cir_level_t  cir_use;
	hw_err_t     cir_err;
	regnum_t     predecode_rs1;
	regnum_t     predecode_rs2;

	// memory model, accepted addresses with the cycle their data is due
	fetch_addr_t fl_addr[$];
	int          fl_due[$];
	int          cycle;
	logic        seen_first;
	// an address was offered and not taken at the last edge
	logic        addr_held_exp;
	// decode model
	fetch_addr_t exp_pc;
	logic        jump_pend;
	fetch_addr_t jump_tgt;
	logic        jump_taken;
	int          starve;
	int          jump_wait;
	// predecode as it was just before the edge, checked against the CIR after it
	regnum_t     pd_rs1;
	regnum_t     pd_rs2;
	logic        pd_vld;
	// consumed instructions waiting for the compare process
	fetch_addr_t rec_pc[$];
	cir_t        rec_instr[$];
	hw_err_t     rec_err[$];
	int          checks;
	int          mismatches;
	int          failures;

	riscv_frontend u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_use         (cir_use),
		.cir_err         (cir_err),
		.predecode_rs1   (predecode_rs1),
		.predecode_rs2   (predecode_rs2)
	);

	always #2 clk = ~clk;

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	// hashed memory contents, so every address holds a different word
	function automatic bus_word_t mem_word(input fetch_addr_t addr);
		bus_word_t h;
		h = addr * 32'h9e37_79b1;
		h = h ^ (h >> 15);
		h = h * 32'h85eb_ca6b;
		return h ^ (h >> 13);
	endfunction

	function automatic halfword_t mem_half(input fetch_addr_t pc);
		bus_word_t w;
		w = mem_word({pc[31:2], 2'b00});
		return pc[1] ? w[31:16] : w[15:0];
	endfunction

	function automatic logic in_err_range(input fetch_addr_t pc);
		return (pc >= err_lo) && (pc < err_hi);
	endfunction

	// low bits 11 mean a 32-bit instruction, the upper half is then the next halfword
	function automatic cir_t ref_instr(input fetch_addr_t pc);
		halfword_t lo;
		lo = mem_half(pc);
		if (lo[1:0] == 2'b11) begin
			return {mem_half(pc + fetch_addr_t'(2)), lo};
		end
		return {16'h0000, lo};
	endfunction

	function automatic hw_err_t ref_err(input fetch_addr_t pc);
		halfword_t lo;
		lo = mem_half(pc);
		if (lo[1:0] == 2'b11) begin
			return {in_err_range(pc + fetch_addr_t'(2)), in_err_range(pc)};
		end
		return {1'b0, in_err_range(pc)};
	endfunction

	function automatic regnum_t ref_rs1(input cir_t i);
		if (i[1:0] == 2'b11) begin
			return i[19:15];
		end
		if ((i[1:0] == 2'b00) && (i[15:13] == 3'b000)) begin
			return 5'd2;
		end
		if (i[1:0] == 2'b01) begin
			return i[11:7];
		end
		if ((i[1:0] == 2'b10) && ((i[15:13] == 3'b100) || (i[15:13] == 3'b000))) begin
			return i[11:7];
		end
		if ((i[1:0] == 2'b10) && ((i[15:13] == 3'b010) || (i[15:13] == 3'b110))) begin
			return 5'd2;
		end
		return 5'd8 + regnum_t'(i[9:7]);
	endfunction

	function automatic regnum_t ref_rs2(input cir_t i);
		if (i[1:0] == 2'b11) begin
			return i[24:20];
		end
		if (i[1:0] == 2'b10) begin
			return i[6:2];
		end
		return 5'd8 + regnum_t'(i[4:2]);
	endfunction

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------

	task automatic check_instr(input string name, input cir_t exp, input cir_t got);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_err(input string name, input hw_err_t exp, input hw_err_t got);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	task automatic check_regnum(input string name, input regnum_t exp, input regnum_t got);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	task automatic check_addr(input string name, input fetch_addr_t exp, input fetch_addr_t got);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	task automatic check_level(input string name, input cir_level_t exp, input cir_level_t got);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		checks++;
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, got);
		end
	endtask

	// ----------------------------------------
	// per-cycle stimulus
	// ----------------------------------------

	// returns data in order once its latency has run out, one word per cycle at most
	task automatic drive_memory();
		mem_addr_rdy = ($urandom % 4) != 0;
		mem_data_vld = 1'b0;
		mem_data = 32'h0;
		mem_data_err = 1'b0;
		if ((fl_addr.size() > 0) && (fl_due[0] <= cycle)) begin
			mem_data_err = in_err_range(fl_addr[0]);
			mem_data = mem_word(fl_addr.pop_front());
			void'(fl_due.pop_front());
			mem_data_vld = 1'b1;
		end
	endtask

	// consumes the whole bottom instruction, stalls at random, and now and then jumps
	task automatic drive_decode();
		logic       wide;
		cir_level_t need;
		wide = (cir_vld != 2'd0) && (cir[1:0] == 2'b11);
		need = wide ? 2'd2 : 2'd1;
		cir_use = 2'd0;
		if (!jump_pend && (($urandom % 48) == 0)) begin
			jump_pend = 1'b1;
			jump_tgt = 32'h0000_1000 + ($urandom & 32'h0000_0ffe);
			jump_target = jump_tgt;
			jump_wait = 0;
		end
		jump_target_vld = jump_pend;
		if (jump_pend) begin
			jump_wait++;
			if (jump_wait > jump_limit) begin
				failures++;
				$display("timeout: jump to %h was not accepted in %0d cycles",
					jump_tgt, jump_limit);
			end
		end else if (cir_vld >= need) begin
			starve = 0;
			if (($urandom % 4) != 0) begin
				cir_use = need;
			end
		end else begin
			starve++;
			if (starve > starve_limit) begin
				failures++;
				$display("timeout: no complete instruction at pc %h for %0d cycles",
					exp_pc, starve);
			end
		end
	endtask

	// what the coming edge does, read once the inputs have settled
	task automatic sample_cycle();
		// jumps are refused only while an address offered at the last edge still waits
		check_flag("jump_target_rdy", !addr_held_exp, jump_target_rdy);
		if (mem_addr_vld && mem_addr_rdy) begin
			if (!seen_first) begin
				check_addr("first mem_addr", `FRONTEND_RESET_VECTOR, mem_addr);
				seen_first = 1'b1;
			end
			fl_addr.push_back(mem_addr);
			fl_due.push_back(cycle + 1 + int'($urandom % 3));
		end
		if (cir_use != 2'd0) begin
			rec_pc.push_back(exp_pc);
			rec_instr.push_back(cir);
			rec_err.push_back(cir_err);
			exp_pc = exp_pc + ((cir_use == 2'd2) ? fetch_addr_t'(4) : fetch_addr_t'(2));
		end
		if (jump_pend && jump_target_rdy) begin
			// nothing fetched before this edge may be consumed afterwards
			exp_pc = jump_tgt;
			jump_pend = 1'b0;
			jump_taken = 1'b1;
		end
		addr_held_exp = mem_addr_vld && !mem_addr_rdy;
		pd_rs1 = predecode_rs1;
		pd_rs2 = predecode_rs2;
		pd_vld = 1'b1;
	endtask

	// ----------------------------------------
	// compare process
	// ----------------------------------------

	always @(negedge clk) begin : compare_proc
		fetch_addr_t pc;
		cir_t        got_instr;
		cir_t        exp_instr;
		hw_err_t     got_err;
		if (jump_taken) begin
			// the edge that takes a jump leaves the CIR empty
			check_level("cir_vld after jump", 2'd0, cir_vld);
			jump_taken = 1'b0;
		end
		if (pd_vld && (cir_vld != 2'd0)) begin
			check_regnum("predecode_rs1", ref_rs1(cir), pd_rs1);
			check_regnum("predecode_rs2", ref_rs2(cir), pd_rs2);
		end
		while (rec_pc.size() > 0) begin
			pc = rec_pc.pop_front();
			got_instr = rec_instr.pop_front();
			got_err = rec_err.pop_front();
			exp_instr = ref_instr(pc);
			// a compressed instruction leaves the upper CIR half to the next one
			if (exp_instr[1:0] != 2'b11) begin
				got_instr[31:16] = 16'h0000;
				got_err[1] = 1'b0;
			end
			check_instr($sformatf("cir at pc %h", pc), exp_instr, got_instr);
			check_err($sformatf("cir_err at pc %h", pc), ref_err(pc), got_err);
		end
	end

	initial begin
		void'($urandom(32'h14de));
		rst_n = 1'b0;
		mem_addr_rdy = 1'b0;
		mem_data = 32'h0;
		mem_data_err = 1'b0;
		mem_data_vld = 1'b0;
		jump_target = 32'h0;
		jump_target_vld = 1'b0;
		cir_use = 2'd0;
		exp_pc = `FRONTEND_RESET_VECTOR;
		seen_first = 1'b0;
		addr_held_exp = 1'b0;
		jump_pend = 1'b0;
		jump_tgt = 32'h0;
		jump_taken = 1'b0;
		starve = 0;
		jump_wait = 0;
		pd_vld = 1'b0;
		pd_rs1 = 5'd0;
		pd_rs2 = 5'd0;
		cycle = 0;
		checks = 0;
		mismatches = 0;
		failures = 0;
		for (int i = 0; i < rst_cycles; i++) begin
			@(negedge clk);
		end
		rst_n = 1'b1;
		#1;
		// the first request is offered in the first cycle after reset with an empty CIR
		check_flag("mem_addr_vld after reset", 1'b1, mem_addr_vld);
		check_addr("mem_addr after reset", `FRONTEND_RESET_VECTOR, mem_addr);
		check_level("cir_vld after reset", 2'd0, cir_vld);
		check_err("cir_err after reset", 2'b00, cir_err);
		addr_held_exp = mem_addr_vld && !mem_addr_rdy;

		for (int c = 0; (c < run_cycles) && (failures == 0); c++) begin
			@(negedge clk);
			cycle = c;
			drive_memory();
			drive_decode();
			#1;
			sample_cycle();
		end
		// let the compare process drain the last records
		@(negedge clk);
		#1;
		$display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
		if ((mismatches == 0) && (failures == 0)) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* verification/frontend_assertions.sv */
// invariant checks bound into the fetch generator and the assembler; fetch_side picks the set
module frontend_assertions
	import fetch_bus_pkg::*;
	import instr_pkg::*;
#(
	// fetch generator invariants when set, decode side invariants otherwise
	parameter bit fetch_side = 1'b1
) (
	input logic         clk,
	input logic         rst_n,
	input pending_cnt_t pending_cnt,
	input pending_cnt_t flush_cnt,
	input logic         addr_hold,
	input logic         mem_addr_vld,
	input fetch_addr_t  mem_addr,
	input cir_level_t   cir_use,
	input cir_level_t   cir_vld
);
	timeunit 1ns;
	timeprecision 1ps;

	if (fetch_side) begin : g_fetch

		// ----------------------------------------
		// fetch tracking
		// ----------------------------------------

		// at most two fetches may be in flight, returned data has no back-pressure
		pending_max: assert property (@(posedge clk) disable iff (!rst_n) pending_cnt <= 2'd2)
			else $error("more than two fetches in flight");

		// only fetches that are still outstanding can be flushed
		flush_bound: assert property (@(posedge clk) disable iff (!rst_n)
			flush_cnt <= pending_cnt)
			else $error("flush count above the pending count");

		// a held address phase repeats the address of the cycle before
		addr_held: assert property (@(posedge clk) disable iff (!rst_n)
			addr_hold |-> (mem_addr == $past(mem_addr)))
			else $error("mem_addr changed while the address phase was held");

	end else begin : g_cir

		// ----------------------------------------
		// decode side
		// ----------------------------------------

		use_bound: assert property (@(posedge clk) disable iff (!rst_n) cir_use <= cir_vld)
			else $error("decode consumed more halfwords than the CIR holds");

	end

endmodule

bind fetch_request_gen frontend_assertions #(.fetch_side(1'b1)) u_fetch_checks (
	.clk          (clk),
	.rst_n        (rst_n),
	.pending_cnt  (pending_cnt),
	.flush_cnt    (flush_cnt),
	.addr_hold    (addr_hold),
	.mem_addr_vld (mem_addr_vld),
	.mem_addr     (mem_addr),
	.cir_use      (2'd0),
	.cir_vld      (2'd0)
);

bind instr_assembler frontend_assertions #(.fetch_side(1'b0)) u_cir_checks (
	.clk          (clk),
	.rst_n        (rst_n),
	.pending_cnt  (2'd0),
	.flush_cnt    (2'd0),
	.addr_hold    (1'b0),
	.mem_addr_vld (1'b0),
	.mem_addr     ('0),
	.cir_use      (cir_use),
	.cir_vld      (cir_vld)
);

/* src/riscv_frontend.sv */
// RV32IC fetch front end top; word-only fetch bus, no back-pressure on returned data
`include "frontend_config.svh"

module riscv_frontend (
	input  logic                        clk,
	input  logic                        rst_n,
	output logic [`FRONTEND_ADDR_W-1:0] mem_addr,
	output logic                        mem_addr_vld,
	input  logic                        mem_addr_rdy,
	input  logic [31:0]                 mem_data,
	input  logic                        mem_data_err,
	input  logic                        mem_data_vld,
	input  logic [`FRONTEND_ADDR_W-1:0] jump_target,
	input  logic                        jump_target_vld,
	output logic                        jump_target_rdy,
	output logic [31:0]                 cir,
	output logic [1:0]                  cir_vld,
	input  logic [1:0]                  cir_use,
	output logic [1:0]                  cir_err,
	output logic [4:0]                  predecode_rs1,
	output logic [4:0]                  predecode_rs2
);

	// fetch control to the data path
	logic        jump_now;
	logic        data_keep;
	logic [1:0]  data_hwvld;
	logic [1:0]  queue_level;
	// queue head towards the assembler
	logic [31:0] queue_word;
	logic        queue_err;
	logic [1:0]  queue_hwvld;
	logic        queue_empty;
	logic        fetch_consume;
	logic [31:0] next_instr;

	fetch_request_gen u_fetch_request_gen (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.queue_level     (queue_level),
		.jump_now        (jump_now),
		.data_keep       (data_keep),
		.data_hwvld      (data_hwvld)
	);

	prefetch_queue u_prefetch_queue (
		.clk           (clk),
		.rst_n         (rst_n),
		.mem_data      (mem_data),
		.mem_data_err  (mem_data_err),
		.data_keep     (data_keep),
		.data_hwvld    (data_hwvld),
		.jump_now      (jump_now),
		.fetch_consume (fetch_consume),
		.queue_word    (queue_word),
		.queue_err     (queue_err),
		.queue_hwvld   (queue_hwvld),
		.queue_empty   (queue_empty),
		.queue_level   (queue_level)
	);

	instr_assembler u_instr_assembler (
		.clk           (clk),
		.rst_n         (rst_n),
		.mem_data      (mem_data),
		.mem_data_err  (mem_data_err),
		.data_keep     (data_keep),
		.jump_now      (jump_now),
		.data_hwvld    (data_hwvld),
		.queue_word    (queue_word),
		.queue_err     (queue_err),
		.queue_hwvld   (queue_hwvld),
		.queue_empty   (queue_empty),
		.cir_use       (cir_use),
		.cir           (cir),
		.cir_vld       (cir_vld),
		.cir_err       (cir_err),
		.fetch_consume (fetch_consume),
		.next_instr    (next_instr)
	);

	regnum_predecode u_regnum_predecode (
		.next_instr    (next_instr),
		.predecode_rs1 (predecode_rs1),
		.predecode_rs2 (predecode_rs2)
	);

endmodule

/* src/regnum_predecode.sv */
// coarse register number predecode; the result may name a register the instruction does not read
module regnum_predecode
	import instr_pkg::*;
(
	input  cir_t    next_instr,
	output regnum_t predecode_rs1,
	output regnum_t predecode_rs2
);

	logic [1:0] quadrant;
	logic [2:0] funct3;

	assign quadrant = next_instr[1:0];
	assign funct3 = next_instr[15:13];

	always_comb begin
		// default is the compressed x8-x15 register field of CIW/CL/CS/CB forms
		predecode_rs1 = {2'b01, next_instr[9:7]};
		predecode_rs2 = {2'b01, next_instr[4:2]};

		case (quadrant)
			2'b11: begin
				// full-width instruction, R/I/S/B field positions
				predecode_rs1 = next_instr[19:15];
				predecode_rs2 = next_instr[24:20];
			end
			2'b00: begin
				// c.addi4spn reads the stack pointer
				if (funct3 == 3'b000) begin
					predecode_rs1 = 5'd2;
				end
			end
			2'b01: begin
				// c.addi, c.addi16sp and friends carry rs1 in the rd field
				predecode_rs1 = next_instr[11:7];
			end
			default: begin
				// quadrant 2 has a full five-bit rs2 field
				predecode_rs2 = next_instr[6:2];
				case (funct3)
					// c.slli, c.mv, c.add, c.jr, c.jalr
					3'b000, 3'b100: predecode_rs1 = next_instr[11:7];
					// c.lwsp and c.swsp are sp relative
					3'b010, 3'b110: predecode_rs1 = 5'd2;
					default: ;
				endcase
			end
		endcase
	end

endmodule

/* src/instr_assembler.sv */
// CIR assembly for RV32IC; decode may consume at most the valid halfwords, one instruction per cycle
module instr_assembler
	import fetch_bus_pkg::*;
	import instr_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  bus_word_t  mem_data,
	input  logic       mem_data_err,
	input  logic       data_keep,
	input  logic       jump_now,
	input  hw_valid_t  data_hwvld,
	input  bus_word_t  queue_word,
	input  logic       queue_err,
	input  hw_valid_t  queue_hwvld,
	input  logic       queue_empty,
	input  cir_level_t cir_use,
	output cir_t       cir,
	output cir_level_t cir_vld,
	output hw_err_t    cir_err,
	output logic       fetch_consume,
	output cir_t       next_instr
);

	// spare halfword above the CIR, holds the tail of a straddling fetch word
	halfword_t  hwbuf;
	buf_level_t buf_level;
	// error flags for {hwbuf, cir upper, cir lower}
	logic [2:0] err_r;

	bus_word_t  fetch_word;
	hw_valid_t  fetch_hw;
	logic       fetch_err;
	logic       fetch_vld;
	bus_word_t  fetch_aligned;
	buf_level_t level_after_use;
	buf_level_t fill_amt;
	buf_level_t level_next;
	logic [47:0] shifted;
	logic [47:0] assembled;
	logic [2:0] err_shifted;
	logic [2:0] err_assembled;

	// --------------------------------------
	// fetch source selection
	// --------------------------------------

	// the queue head is older than anything on the bus, so it wins when present
	assign fetch_word = queue_empty ? mem_data : queue_word;
	assign fetch_hw = queue_empty ? data_hwvld : queue_hwvld;
	assign fetch_err = queue_empty ? mem_data_err : queue_err;
	assign fetch_vld = !queue_empty || data_keep;

	// a word entered at an odd halfword brings only its upper half down to slot 0
	assign fetch_aligned = {
		fetch_word[31:16],
		fetch_hw[0] ? fetch_word[15:0] : fetch_word[31:16]
	};

	// --------------------------------------
	// consume and fill
	// --------------------------------------

	assign level_after_use = buf_level - buf_level_t'(cir_use);

	// a full word needs two free slots of three, a single halfword needs one
	assign fetch_consume = (fetch_hw == 2'b11) ? (level_after_use <= 2'd1)
		: (level_after_use <= 2'd2);

	always_comb begin
		// slots above the remaining level are don't-care and are filled cheaply
		case (cir_use)
			2'd2: begin
				shifted = {hwbuf, hwbuf, hwbuf};
				err_shifted = {3{err_r[2]}};
			end
			2'd1: begin
				shifted = {hwbuf, hwbuf, cir[31:16]};
				err_shifted = {err_r[2], err_r[2], err_r[1]};
			end
			default: begin
				shifted = {hwbuf, cir};
				err_shifted = err_r;
			end
		endcase

		// fresh halfwords land at the first free slot after consumption
		assembled = shifted;
		err_assembled = err_shifted;
		if (fetch_consume) begin
			case (level_after_use)
				2'd2: begin
					assembled = {fetch_aligned[15:0], shifted[31:0]};
					err_assembled = {fetch_err, err_shifted[1:0]};
				end
				2'd1: begin
					assembled = {fetch_aligned, shifted[15:0]};
					err_assembled = {fetch_err, fetch_err, err_shifted[0]};
				end
				default: begin
					assembled = {shifted[47:32], fetch_aligned};
					err_assembled = {err_shifted[2], fetch_err, fetch_err};
				end
			endcase
		end
	end

	assign fill_amt = !(fetch_consume && fetch_vld) ? 2'd0
		: (fetch_hw == 2'b11) ? 2'd2 : 2'd1;

	assign level_next = jump_now ? 2'd0 : level_after_use + fill_amt;

	// --------------------------------------
	// state
	// --------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld <= 2'd0;
			err_r <= 3'b000;
		end else begin
			buf_level <= level_next;
			// decode only ever sees up to two halfwords
			cir_vld <= (level_next == 2'd3) ? 2'd2 : cir_level_t'(level_next);
			err_r <= err_assembled;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= assembled;
	end

	assign cir_err = err_r[1:0];

	// predecode looks at what the CIR is about to become
	assign next_instr = assembled[31:0];

endmodule

/* src/prefetch_queue.sv */
// compacting prefetch queue; entry 0 is always the oldest and the queue never overflows
`include "frontend_config.svh"

module prefetch_queue
	import fetch_bus_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  bus_word_t    mem_data,
	input  logic         mem_data_err,
	input  logic         data_keep,
	input  hw_valid_t    data_hwvld,
	input  logic         jump_now,
	input  logic         fetch_consume,
	output bus_word_t    queue_word,
	output logic         queue_err,
	output hw_valid_t    queue_hwvld,
	output logic         queue_empty,
	output pending_cnt_t queue_level
);

	localparam int depth = `FRONTEND_QUEUE_DEPTH;

	bus_word_t ent_word [depth];
	logic      ent_err  [depth];
	hw_valid_t ent_hw   [depth];

	// the extra top slot stands for the incoming bus word so every entry
	// shifts from its upper neighbour with one expression
	bus_word_t up_word  [depth+1];
	logic      up_err   [depth+1];
	hw_valid_t up_hw    [depth+1];
	logic      up_vld   [depth+1];
	// validity of the lower neighbour, entry 0 sees a virtual valid slot
	logic      low_vld  [depth];

	logic push;
	logic pop;

	always_comb begin
		for (int i = 0; i < depth; i++) begin
			up_word[i] = ent_word[i];
			up_err[i] = ent_err[i];
			up_hw[i] = ent_hw[i];
			up_vld[i] = |ent_hw[i];
			low_vld[i] = (i == 0) ? 1'b1 : |ent_hw[(i == 0) ? 0 : i - 1];
		end
		up_word[depth] = mem_data;
		up_err[depth] = mem_data_err;
		up_hw[depth] = 2'b00;
		up_vld[depth] = 1'b0;
	end

	assign queue_empty = !up_vld[0];

	// a word that goes straight to the CIR is not also written here
	assign push = data_keep && !(queue_empty && fetch_consume);
	assign pop = fetch_consume && !queue_empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < depth; i++) begin
				ent_hw[i] <= 2'b00;
			end
		end else begin
			for (int i = 0; i < depth; i++) begin
				if (jump_now) begin
					ent_hw[i] <= 2'b00;
				end else if (pop) begin
					// shift down, and the tail slot that opens up takes the new word
					if (up_vld[i+1]) begin
						ent_hw[i] <= up_hw[i+1];
					end else if (up_vld[i]) begin
						ent_hw[i] <= push ? data_hwvld : 2'b00;
					end
				end else if (!up_vld[i] && push && low_vld[i]) begin
					ent_hw[i] <= data_hwvld;
				end
			end
		end
	end

	// word and error bits follow the same movement and are qualified by ent_hw
	always_ff @(posedge clk) begin
		for (int i = 0; i < depth; i++) begin
			if (pop || (push && !up_vld[i])) begin
				ent_word[i] <= up_vld[i+1] ? up_word[i+1] : mem_data;
				ent_err[i] <= up_vld[i+1] ? up_err[i+1] : mem_data_err;
			end
		end
	end

	always_comb begin
		queue_level = 2'd0;
		for (int i = 0; i < depth; i++) begin
			queue_level = queue_level + pending_cnt_t'(up_vld[i]);
		end
	end

	assign queue_word = ent_word[0];
	assign queue_err = ent_err[0];
	assign queue_hwvld = ent_hw[0];

endmodule

/* src/fetch_request_gen.sv */
// fetch address and in-flight tracking; the memory must return data in order and never stall it
`include "frontend_config.svh"

module fetch_request_gen
	import fetch_bus_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	output fetch_addr_t  mem_addr,
	output logic         mem_addr_vld,
	input  logic         mem_addr_rdy,
	input  logic         mem_data_vld,
	input  fetch_addr_t  jump_target,
	input  logic         jump_target_vld,
	output logic         jump_target_rdy,
	input  pending_cnt_t queue_level,
	output logic         jump_now,
	output logic         data_keep,
	output hw_valid_t    data_hwvld
);

	localparam pending_cnt_t queue_full_lvl   = pending_cnt_t'(`FRONTEND_QUEUE_DEPTH);
	localparam pending_cnt_t queue_almost_lvl = pending_cnt_t'(`FRONTEND_QUEUE_DEPTH - 1);

	// next sequential word to request, runs ahead of decode
	fetch_addr_t  fetch_addr;
	// an address phase was offered and not yet accepted
	logic         addr_hold;
	pending_cnt_t pending_cnt;
	// responses still owed to fetches issued before the last jump
	pending_cnt_t flush_cnt;
	// the next kept word starts at an odd jump target
	logic         first_odd;

	logic        addr_accept;
	logic        fetch_stall;
	logic        two_pending;
	fetch_addr_t jump_word;
	fetch_addr_t jump_next;

	// --------------------------------------
	// request generation
	// --------------------------------------

	// all stall terms are registered so mem_addr_rdy never feeds back into the request
	assign two_pending = pending_cnt >= 2'd2;
	assign fetch_stall = (queue_level >= queue_full_lvl)
		|| ((queue_level >= queue_almost_lvl) && (pending_cnt != 2'd0))
		|| two_pending;

	assign jump_word = {jump_target[`FRONTEND_ADDR_W-1:2], 2'b00};

	always_comb begin
		mem_addr = fetch_addr;
		mem_addr_vld = 1'b0;
		if (addr_hold) begin
			// a held request must be offered unchanged until it is taken
			mem_addr_vld = 1'b1;
		end else if (jump_target_vld) begin
			// the queue is flushed by the jump, so only the in-flight limit applies
			mem_addr = jump_word;
			mem_addr_vld = !two_pending;
		end else if (!fetch_stall) begin
			mem_addr_vld = 1'b1;
		end
	end

	assign addr_accept = mem_addr_vld && mem_addr_rdy;
	assign jump_target_rdy = !addr_hold;
	assign jump_now = jump_target_vld && jump_target_rdy;

	// skip the target word when it was requested in the same cycle as the jump
	assign jump_next = jump_word + (addr_accept ? fetch_addr_t'(4) : fetch_addr_t'(0));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= `FRONTEND_RESET_VECTOR;
			addr_hold <= 1'b0;
		end else begin
			addr_hold <= mem_addr_vld && !mem_addr_rdy;
			if (jump_now) begin
				fetch_addr <= jump_next;
			end else if (addr_accept) begin
				fetch_addr <= fetch_addr + fetch_addr_t'(4);
			end
		end
	end

	// --------------------------------------
	// in-flight tracking
	// --------------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending_cnt <= 2'd0;
			flush_cnt <= 2'd0;
		end else begin
			pending_cnt <= pending_cnt + pending_cnt_t'(addr_accept)
				- pending_cnt_t'(mem_data_vld);
			if (jump_now) begin
				// everything still outstanding at the jump belongs to the old stream
				flush_cnt <= pending_cnt - pending_cnt_t'(mem_data_vld);
			end else if ((flush_cnt != 2'd0) && mem_data_vld) begin
				flush_cnt <= flush_cnt - 2'd1;
			end
		end
	end

	assign data_keep = mem_data_vld && (flush_cnt == 2'd0);

	// only the first word after a jump can lose its lower halfword, since all
	// older in-flight words are discarded by the flush count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			first_odd <= 1'b0;
		end else if (jump_now) begin
			first_odd <= jump_target[1];
		end else if (data_keep) begin
			first_odd <= 1'b0;
		end
	end

	assign data_hwvld = {1'b1, !first_odd};

endmodule

/* src/instr_pkg.sv */
// instruction-side types for RV32IC assembly; the CIR holds at most two halfwords
package instr_pkg;

	// a single 16-bit parcel, either a compressed instruction or half of a 32-bit one
	typedef logic [15:0] halfword_t;

	// current instruction register as seen by decode
	// the oldest halfword sits in bits 15:0
	typedef logic [31:0] cir_t;

	// valid halfwords in the CIR, 0 to 2
	typedef logic [1:0] cir_level_t;

	// valid halfwords in the CIR plus the spare halfword buffer, 0 to 3
	typedef logic [1:0] buf_level_t;

	// bus error flag for the lower (bit 0) and upper (bit 1) halfword of the CIR
	typedef logic [1:0] hw_err_t;

	// architectural register number
	typedef logic [4:0] regnum_t;

endpackage

/* src/fetch_bus_pkg.sv */
// memory-side fetch bus types; fetches are always full words and at most two are in flight
`include "frontend_config.svh"

package fetch_bus_pkg;

	// byte address driven on the fetch bus, the low two bits are always zero on requests
	typedef logic [`FRONTEND_ADDR_W-1:0] fetch_addr_t;

	// one word of returned instruction data
	typedef logic [31:0] bus_word_t;

	// bit 0 marks the lower halfword valid and bit 1 the upper halfword
	typedef logic [1:0] hw_valid_t;

	// number of fetches in flight or still to be discarded, never above 2
	// also reused for the occupancy of the two-entry prefetch queue
	typedef logic [1:0] pending_cnt_t;

endpackage

/* include/frontend_config.svh */
// build-time constants for the fetch front end; a queue depth below 2 costs fetch throughput
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// --------------------------------------
// address space
// --------------------------------------

// width of every fetch and jump address
`define FRONTEND_ADDR_W 32

// first word fetched after reset, must be word-aligned
`define FRONTEND_RESET_VECTOR 32'h0000_1000

// --------------------------------------
// prefetch buffering
// --------------------------------------

// entries in the prefetch queue, two is the minimum for back-to-back fetches
`define FRONTEND_QUEUE_DEPTH 2

`endif
